// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := mem_driver_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
source/mem_driver_pkg.sv
source/mem_client_driver.sv
source/mem_req_queue.sv
source/line_memory.sv
source/mem_driver_top.sv
verification/mem_driver_tb.sv

// ==== source/line_memory.sv ====
module line_memory
    import mem_driver_pkg::*;
#(
    parameter int unsigned read_latency = 2
)
(
    input  logic       clk,
    input  logic       reset,

    // Head of the request queue
    input  mem_req_t   head_word,
    input  logic       not_empty,
    output logic       pop,

    // Read responses and write acknowledgements
    output logic       rsp_valid,
    output req_tag_t   rsp_tag,
    output line_data_t rsp_data,
    output logic       ack_valid
);

    localparam int num_lines = 1 << $bits(line_addr_t);

    // Line storage, contents undefined until written
    line_data_t mem_array [num_lines];

    // Fields of the request at the head of the queue
    req_op_t head_op;
    req_tag_t head_tag;
    line_addr_t head_addr;
    line_data_t head_data;

    logic do_read;
    logic do_write;

    // Read pipeline, one stage per cycle of latency
    logic [read_latency-1:0] rd_valid_pipe;
    req_tag_t rd_tag_pipe [read_latency];
    line_data_t rd_data_pipe [read_latency];

    // ================================================
    // Request decode
    // ================================================

    assign head_op = req_op_t'(head_word[req_op_bit]);
    assign head_tag = head_word[req_tag_lsb +: $bits(req_tag_t)];
    assign head_addr = head_word[req_addr_lsb +: $bits(line_addr_t)];
    assign head_data = head_word[req_data_lsb +: $bits(line_data_t)];

    // The memory never stalls, so it takes the head whenever one is there
    assign pop = not_empty;
    assign do_read = pop && (head_op == op_read);
    assign do_write = pop && (head_op == op_write);

    // ================================================
    // Execution
    // ================================================

    // A write lands at the edge after its pop, so a read popped next sees it
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem_array[head_addr] <= head_data;
        end
    end

    // Stage 0 samples the array, later stages only shift data and tag along
    always_ff @(posedge clk)
    begin
        rd_tag_pipe[0] <= head_tag;
        rd_data_pipe[0] <= mem_array[head_addr];
        for (int i = 1; i < read_latency; i++)
        begin
            rd_tag_pipe[i] <= rd_tag_pipe[i-1];
            rd_data_pipe[i] <= rd_data_pipe[i-1];
        end
    end

    // Valid bits and the write ack are control state and clear on reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_valid_pipe <= '0;
            ack_valid <= 1'b0;
        end
        else
        begin
            rd_valid_pipe[0] <= do_read;
            for (int i = 1; i < read_latency; i++)
            begin
                rd_valid_pipe[i] <= rd_valid_pipe[i-1];
            end
            ack_valid <= do_write;
        end
    end

    assign rsp_valid = rd_valid_pipe[read_latency-1];
    assign rsp_tag = rd_tag_pipe[read_latency-1];
    assign rsp_data = rd_data_pipe[read_latency-1];

endmodule

// ==== source/mem_client_driver.sv ====
module mem_client_driver
    import mem_driver_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Client read request
    input  line_addr_t read_req_addr,
    input  logic       read_req_enable,

    // Client write request
    input  line_addr_t write_addr,
    input  line_data_t write_data,
    input  logic       write_enable,

    // Back-pressure toward the client
    output logic       req_ready,
    input  logic       almost_full,

    // Request word toward the queue
    output logic       push,
    output mem_req_t   push_word,

    // Responses from the memory
    input  logic       rsp_valid,
    input  req_tag_t   rsp_tag,
    input  line_data_t rsp_data,
    input  logic       ack_valid,

    // Responses toward the client
    output logic       read_rsp_valid,
    output line_data_t read_rsp_data,
    output logic       write_ack,
    output logic       tag_error
);

    // Tag of the next read request, the next write request and the next read response
    req_tag_t read_req_tag;
    req_tag_t write_req_tag;
    req_tag_t rsp_tag_expected;

    // A write only goes out when no read claims the same cycle
    logic write_push;
    logic tag_mismatch;

    // ================================================
    // Request side
    // ================================================

    // Ready drops as soon as the queue reaches its almost-full level
    assign req_ready = !almost_full;

    assign write_push = write_enable && !read_req_enable;
    assign push = read_req_enable || write_enable;

    // Pack the request word, with the read taking priority on a conflict
    always_comb
    begin
        push_word = '0;
        if (read_req_enable)
        begin
            push_word[req_op_bit] = op_read;
            push_word[req_tag_lsb +: $bits(req_tag_t)] = read_req_tag;
            push_word[req_addr_lsb +: $bits(line_addr_t)] = read_req_addr;
        end
        else
        begin
            push_word[req_op_bit] = op_write;
            push_word[req_tag_lsb +: $bits(req_tag_t)] = write_req_tag;
            push_word[req_addr_lsb +: $bits(line_addr_t)] = write_addr;
            push_word[req_data_lsb +: $bits(line_data_t)] = write_data;
        end
    end

    // ================================================
    // Response side
    // ================================================

    // Responses pass straight through to the client in the cycle they arrive
    assign read_rsp_valid = rsp_valid;
    assign read_rsp_data = rsp_data;
    assign write_ack = ack_valid;

    // Reads come back in issue order, so each response must carry the next tag
    assign tag_mismatch = rsp_valid && (rsp_tag != rsp_tag_expected);

    // Each counter advances on its own event only
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            read_req_tag <= read_tag_start;
            write_req_tag <= write_tag_start;
            rsp_tag_expected <= read_tag_start;
        end
        else
        begin
            if (read_req_enable)
            begin
                read_req_tag <= read_req_tag + 1'b1;
            end

            if (write_push)
            begin
                write_req_tag <= write_req_tag + 1'b1;
            end

            if (rsp_valid)
            begin
                rsp_tag_expected <= rsp_tag_expected + 1'b1;
            end
        end
    end

    // Sticky error flag, cleared only by reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tag_error <= 1'b0;
        end
        else if (tag_mismatch)
        begin
            tag_error <= 1'b1;
        end
    end

    // ================================================
    // Protocol checks
    // ================================================

    // A client may only issue while the queue has room beyond the slack
    assert property (@(posedge clk) disable iff (reset)
        (read_req_enable || write_enable) |-> req_ready)
        else $error("mem_client_driver: request issued while not ready");

    // Reads and writes share one queue and one push per cycle
    assert property (@(posedge clk) disable iff (reset)
        !(read_req_enable && write_enable))
        else $error("mem_client_driver: read and write enabled together");

    // The memory must return reads in the order the driver tagged them
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> (rsp_tag == rsp_tag_expected))
        else $error("mem_client_driver: read tag 0x%0h, expected 0x%0h",
            rsp_tag, rsp_tag_expected);

endmodule

// ==== source/mem_driver_pkg.sv ====
package mem_driver_pkg;

    // ================================================
    // Widths that carry a meaning
    // ================================================

    // Cache-line address covers a 1024-line memory
    typedef logic [9:0] line_addr_t;

    // One cache line of payload
    typedef logic [63:0] line_data_t;

    // Request tag carried alongside each request
    typedef logic [7:0] req_tag_t;

    // Request opcode stored in the top bit of the request word
    typedef enum logic
    {
        op_read  = 1'b0,
        op_write = 1'b1
    } req_op_t;

    // ================================================
    // Request word layout
    // ================================================

    // Fields are packed from the bottom up as data, address, tag and op
    localparam int req_data_lsb = 0;
    localparam int req_addr_lsb = req_data_lsb + $bits(line_data_t);
    localparam int req_tag_lsb = req_addr_lsb + $bits(line_addr_t);
    localparam int req_op_bit = req_tag_lsb + $bits(req_tag_t);
    localparam int req_word_width = req_op_bit + 1;

    // The request word that travels through the queue, 83 bits in all
    typedef logic [req_word_width-1:0] mem_req_t;

    // Odd starting tags so that a stuck or misaligned counter shows up quickly
    localparam req_tag_t read_tag_start = 8'd27;
    localparam req_tag_t write_tag_start = 8'd13;

endpackage

// ==== source/mem_driver_top.sv ====
module mem_driver_top
    import mem_driver_pkg::*;
#(
    parameter int unsigned queue_depth = 8,
    parameter int unsigned almost_full_slack = 2,
    parameter int unsigned read_latency = 2
)
(
    input  logic       clk,
    input  logic       reset,

    // Client requests
    input  line_addr_t read_req_addr,
    input  logic       read_req_enable,
    input  line_addr_t write_addr,
    input  line_data_t write_data,
    input  logic       write_enable,
    output logic       req_ready,

    // Client responses
    output logic       read_rsp_valid,
    output line_data_t read_rsp_data,
    output logic       write_ack,
    output logic       tag_error
);

    // ================================================
    // Stage interconnect
    // ================================================

    // Driver to queue
    logic push;
    mem_req_t push_word;
    logic almost_full;

    // Queue to memory
    mem_req_t head_word;
    logic not_empty;
    logic pop;

    // Memory back to the driver
    logic rsp_valid;
    req_tag_t rsp_tag;
    line_data_t rsp_data;
    logic ack_valid;

    // Tags requests and checks response order
    mem_client_driver mem_client_driver_i
    (
        .clk,
        .reset,
        .read_req_addr,
        .read_req_enable,
        .write_addr,
        .write_data,
        .write_enable,
        .req_ready,
        .almost_full,
        .push,
        .push_word,
        .rsp_valid,
        .rsp_tag,
        .rsp_data,
        .ack_valid,
        .read_rsp_valid,
        .read_rsp_data,
        .write_ack,
        .tag_error
    );

    // One queue for reads and writes keeps load/store order intact
    mem_req_queue #(
        .queue_depth(queue_depth),
        .almost_full_slack(almost_full_slack)
    ) mem_req_queue_i
    (
        .clk,
        .reset,
        .push,
        .push_word,
        .almost_full,
        .pop,
        .head_word,
        .not_empty
    );

    line_memory #(
        .read_latency(read_latency)
    ) line_memory_i
    (
        .clk,
        .reset,
        .head_word,
        .not_empty,
        .pop,
        .rsp_valid,
        .rsp_tag,
        .rsp_data,
        .ack_valid
    );

endmodule

// ==== source/mem_req_queue.sv ====
module mem_req_queue
    import mem_driver_pkg::*;
#(
    parameter int unsigned queue_depth = 8,
    parameter int unsigned almost_full_slack = 2
)
(
    input  logic     clk,
    input  logic     reset,

    // Write side, fed by the driver
    input  logic     push,
    input  mem_req_t push_word,
    output logic     almost_full,

    // Read side, drained by the memory
    input  logic     pop,
    output mem_req_t head_word,
    output logic     not_empty
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_w = $clog2(queue_depth + 1);

    // Occupancy levels in the width of the count register
    localparam logic [count_w-1:0] full_level = count_w'(queue_depth);
    localparam logic [count_w-1:0] almost_full_level = count_w'(queue_depth - almost_full_slack);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(queue_depth - 1);

    // Storage holds payload only and needs no reset
    mem_req_t storage [queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [count_w-1:0] count;
    logic full;

    assign full = (count == full_level);
    assign not_empty = (count != '0);

    // Ready to the client falls while almost_full_slack slots are still free
    assign almost_full = (count >= almost_full_level);

    // The head is visible combinationally so the memory can pop it at once
    assign head_word = storage[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            storage[wr_ptr] <= push_word;
        end
    end

    // Pointers wrap explicitly so that any depth works, not just powers of two
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end

            if (pop)
            begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leave the occupancy unchanged
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // The driver's back-pressure must keep a full queue from seeing a push
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("mem_req_queue: push into a full queue");

    // The memory may only pop while something is queued
    assert property (@(posedge clk) disable iff (reset) pop |-> not_empty)
        else $error("mem_req_queue: pop from an empty queue");

endmodule

// ==== verification/mem_driver_tb.sv ====
module mem_driver_tb
    import mem_driver_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 40;
    localparam int drive_delay = 2;
    localparam int wait_limit = 200;
    localparam int burst_pairs = 8;

    // The memory drains one request per cycle, so occupancy never passes one
    // A slack of depth minus one is the only setting where req_ready can fall
    localparam int unsigned tb_queue_depth = 4;
    localparam int unsigned tb_almost_full_slack = 3;
    localparam int unsigned tb_read_latency = 3;

    localparam logic [31:0] rand_seed = 32'h9733_7e08;

    // One row of the stimulus table
    typedef struct {
        string      name;
        req_op_t    op;
        line_addr_t addr;
        line_data_t data;
        bit         gap;
    } step_t;

    logic       clk;
    logic       reset;
    line_addr_t read_req_addr;
    logic       read_req_enable;
    line_addr_t write_addr;
    line_data_t write_data;
    logic       write_enable;
    logic       req_ready;
    logic       read_rsp_valid;
    line_data_t read_rsp_data;
    logic       write_ack;
    logic       tag_error;

    step_t steps[$];

    // Mirror of the memory contents, updated in issue order
    line_data_t mirror [1024];

    // Expected read data with the name of the step that issued it
    line_data_t exp_data[$];
    string      exp_name[$];

    int  error_count = 0;
    int  timeout_count = 0;
    int  reads_issued = 0;
    int  writes_issued = 0;
    int  acks_seen = 0;
    bit  timed_out = 0;
    bit  in_burst = 0;
    bit  ready_fell = 0;
    bit  tag_error_seen = 0;

    mem_driver_top #(
        .queue_depth(tb_queue_depth),
        .almost_full_slack(tb_almost_full_slack),
        .read_latency(tb_read_latency)
    ) mem_driver_top_i
    (
        .clk,
        .reset,
        .read_req_addr,
        .read_req_enable,
        .write_addr,
        .write_data,
        .write_enable,
        .req_ready,
        .read_rsp_valid,
        .read_rsp_data,
        .write_ack,
        .tag_error
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ================================================
    // Helpers
    // ================================================

    task automatic report_mismatch(input string name, input line_data_t expected,
                                   input line_data_t actual);
        $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        error_count++;
    endtask

    task automatic add_step(input string name, input req_op_t op, input line_addr_t addr,
                            input line_data_t data, input bit gap);
        step_t row;
        row.name = name;
        row.op = op;
        row.addr = addr;
        row.data = data;
        row.gap = gap;
        steps.push_back(row);
    endtask

    function automatic line_data_t random_line();
        return {$urandom, $urandom};
    endfunction

    // Every read below targets an address that an earlier row wrote
    task automatic build_table();
        line_addr_t burst_addr;
        line_addr_t prev_addr;
        add_step("write_read_gap", op_write, 10'h05a, random_line(), 1'b1);
        add_step("write_read_gap", op_read, 10'h05a, '0, 1'b1);

        // Old value first, then the new one goes in right before the read
        add_step("back_to_back", op_write, 10'h133, random_line(), 1'b1);
        add_step("back_to_back", op_write, 10'h133, random_line(), 1'b0);
        add_step("back_to_back", op_read, 10'h133, '0, 1'b1);

        prev_addr = 10'h05a;
        for (int i = 0; i < burst_pairs; i++)
        begin
            burst_addr = line_addr_t'($urandom);
            add_step("burst", op_write, burst_addr, random_line(), 1'b0);
            add_step("burst", op_read, (i % 2 == 1) ? burst_addr : prev_addr, '0,
                     i == burst_pairs - 1);
            prev_addr = burst_addr;
        end

        add_step("interleave", op_write, 10'h2a0, random_line(), 1'b0);
        add_step("interleave", op_write, 10'h0f3, random_line(), 1'b0);
        add_step("interleave", op_read, 10'h2a0, '0, 1'b0);
        add_step("interleave", op_read, 10'h0f3, '0, 1'b0);
        add_step("interleave", op_write, 10'h2a0, random_line(), 1'b0);
        add_step("interleave", op_read, 10'h0f3, '0, 1'b0);
        add_step("interleave", op_read, 10'h2a0, '0, 1'b1);
    endtask

    // Called at the drive point, a little after a rising edge
    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        while (!req_ready && cycles < wait_limit)
        begin
            @(posedge clk);
            #drive_delay;
            cycles++;
        end
        if (!req_ready)
        begin
            $display("Timeout: req_ready stayed low for %0d cycles in step %s", cycles, name);
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    // Waits until every issued read has returned and every write has been acked
    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while ((exp_data.size() != 0 || acks_seen != writes_issued) && cycles < wait_limit)
        begin
            @(posedge clk);
            #drive_delay;
            cycles++;
        end
        if (exp_data.size() != 0 || acks_seen != writes_issued)
        begin
            $display("Timeout: responses still missing after %0d cycles in %s", cycles, name);
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    // One enable pulse, one cycle wide, with the mirror updated at issue
    task automatic apply_step(input step_t row);
        in_burst = (row.name == "burst");
        wait_ready(row.name);
        if (!timed_out)
        begin
            if (row.op == op_write)
            begin
                write_addr = row.addr;
                write_data = row.data;
                write_enable = 1'b1;
                mirror[row.addr] = row.data;
                writes_issued++;
            end
            else
            begin
                read_req_addr = row.addr;
                read_req_enable = 1'b1;
                exp_data.push_back(mirror[row.addr]);
                exp_name.push_back(row.name);
                reads_issued++;
            end
            @(posedge clk);
            #drive_delay;
            write_enable = 1'b0;
            read_req_enable = 1'b0;
            if (row.gap)
            begin
                wait_idle(row.name);
            end
        end
    endtask

    // ================================================
    // Response monitor
    // ================================================

    // Sampled on the falling edge, well away from the drive point
    always @(negedge clk)
    begin
        line_data_t expected;
        string name;
        if (!reset)
        begin
            if (read_rsp_valid)
            begin
                if (exp_data.size() == 0)
                begin
                    $display("Read response arrived with no read outstanding, data 0x%0h",
                             read_rsp_data);
                    error_count++;
                end
                else
                begin
                    expected = exp_data.pop_front();
                    name = exp_name.pop_front();
                    if (read_rsp_data !== expected)
                    begin
                        report_mismatch(name, expected, read_rsp_data);
                    end
                end
            end
            // Each write earns exactly one ack, so an ack beyond the writes issued is extra
            if (write_ack)
            begin
                if (acks_seen >= writes_issued)
                begin
                    $display("Write acknowledgement arrived with no write outstanding");
                    error_count++;
                end
                else
                begin
                    acks_seen++;
                end
            end
            if (in_burst && !req_ready)
            begin
                ready_fell = 1'b1;
            end
            // Reported once, since the flag is sticky
            if (tag_error !== 1'b0 && !tag_error_seen)
            begin
                report_mismatch("tag_error", 64'(1'b0), 64'(tag_error));
                tag_error_seen = 1'b1;
            end
        end
    end

    // ================================================
    // Main sequence
    // ================================================

    initial
    begin
        void'($urandom(rand_seed));
        reset = 1'b1;
        read_req_addr = '0;
        read_req_enable = 1'b0;
        write_addr = '0;
        write_data = '0;
        write_enable = 1'b0;
        build_table();

        repeat (2) @(posedge clk);
        #drive_delay;
        reset = 1'b0;

        // Idle state right after reset
        if (req_ready !== 1'b1)
        begin
            report_mismatch("reset_req_ready", 64'(1'b1), 64'(req_ready));
        end
        if (read_rsp_valid !== 1'b0)
        begin
            report_mismatch("reset_read_rsp_valid", 64'(1'b0), 64'(read_rsp_valid));
        end
        if (write_ack !== 1'b0)
        begin
            report_mismatch("reset_write_ack", 64'(1'b0), 64'(write_ack));
        end
        if (tag_error !== 1'b0)
        begin
            report_mismatch("reset_tag_error", 64'(1'b0), 64'(tag_error));
        end

        for (int i = 0; i < steps.size() && !timed_out; i++)
        begin
            apply_step(steps[i]);
        end
        in_burst = 1'b0;

        if (!timed_out)
        begin
            wait_idle("final drain");
        end

        // The burst must have pushed the queue to its almost-full level
        if (!timed_out)
        begin
            if (!ready_fell)
            begin
                $display("req_ready never fell during the burst, back-pressure was not seen");
                error_count++;
            end
        end

        $display("Done: %0d reads, %0d writes, %0d errors, %0d timeouts",
                 reads_issued, writes_issued, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
